/* rtl/pid_coef_if.sv */
`timescale 1ns/1ps

interface pid_coef_if import pid_pkg::*; ();

    coef_t kp;
    coef_t ki;
    coef_t kd_1;
    coef_t kd_2;

    // the register bank owns the gains.
    modport regs (
        output kp,
        output ki,
        output kd_1,
        output kd_2
    );

    // the core samples them as levels on each iterate pulse.
    modport core (
        input kp,
        input ki,
        input kd_1,
        input kd_2
    );

endinterface

/* rtl/pid_coef_regs.sv */
`timescale 1ns/1ps

module pid_coef_regs import pid_pkg::*; (
    input  logic    i_clock,
    input  logic    i_reset,
    input  logic    i_write_enable,
    input  addr_t   i_reg_addr,
    input  sample_t i_reg_data,
    pid_coef_if.regs coef,
    output period_t o_period,
    output logic    o_period_load
);

    period_t raw_period;
    period_t wr_period;

    assign raw_period = i_reg_data[PERIOD_WIDTH-1:0]; // the period is unsigned.

    always_comb begin
        if (raw_period != '0 && raw_period < PERIOD_MIN) begin
            wr_period = PERIOD_MIN; // a period of one would fire on every cycle.
        end else begin
            wr_period = raw_period;
        end
    end

    always_ff @(posedge i_clock or negedge i_reset) begin
        if (!i_reset) begin
            coef.kp <= '0;
            coef.ki <= '0;
            coef.kd_1 <= '0;
            coef.kd_2 <= '0;
            o_period <= '0;
            o_period_load <= 1'b0;
        end else begin
            o_period_load <= 1'b0;
            if (i_write_enable) begin
                case (i_reg_addr)
                    ADDR_KP: begin
                        coef.kp <= i_reg_data;
                    end
                    ADDR_KI: begin
                        coef.ki <= i_reg_data;
                    end
                    ADDR_KD1: begin
                        coef.kd_1 <= i_reg_data;
                    end
                    ADDR_KD2: begin
                        coef.kd_2 <= i_reg_data;
                    end
                    ADDR_PERIOD: begin
                        o_period <= wr_period;
                        o_period_load <= 1'b1; // tells the timer to restart its count.
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // the timer relies on never seeing a period shorter than the minimum.
    a_period_min: assert property (
        @(posedge i_clock) disable iff (!i_reset)
        !(o_period != '0 && o_period < PERIOD_MIN)
    );

endmodule

/* rtl/pid_core.sv */
`timescale 1ns/1ps

module pid_core import pid_pkg::*; (
    input  logic    i_clock,
    input  logic    i_reset,
    input  logic    i_iterate,
    input  sample_t i_target,
    input  sample_t i_measurement,
    pid_coef_if.core coef,
    output sample_t o_out,
    output logic    o_out_valid
);

    sample_t error;
    sample_t prev_error;
    sample_t integ;
    sample_t prev_deriv;

    product_t p_mult;
    product_t i_mult;
    product_t d_mult_1;
    product_t d_mult_2;

    sample_t p_term;
    sample_t i_cand;
    sample_t i_clamped;
    sample_t d_term;

    // headroom and output sums are kept two bits wider so they cannot wrap.
    logic signed [D_WIDTH+1:0] hi_bound;
    logic signed [D_WIDTH+1:0] lo_bound;
    logic signed [D_WIDTH+1:0] out_sum;
    sample_t out_next;

    always_comb begin
        error = i_target - i_measurement;

        p_mult = product_t'(error) * product_t'(coef.kp);
        p_term = sample_t'(p_mult >>> Q_BITS);

        // trapezoidal step on the sum of the current and previous error.
        i_mult = product_t'(coef.ki) * (product_t'(error) + product_t'(prev_error));
        i_cand = integ + sample_t'(i_mult >>> Q_BITS);

        d_mult_1 = product_t'(coef.kd_1) * (product_t'(error) - product_t'(prev_error));
        d_mult_2 = product_t'(coef.kd_2) * product_t'(prev_deriv);
        d_term = sample_t'(d_mult_1 >>> Q_BITS) + sample_t'(d_mult_2 >>> Q_BITS);

        // the integrator may only use what the proportional term leaves free.
        if (LIM_MAX > p_term) begin
            hi_bound = LIM_MAX - p_term;
        end else begin
            hi_bound = '0;
        end
        if (LIM_MIN < p_term) begin
            lo_bound = LIM_MIN - p_term;
        end else begin
            lo_bound = '0;
        end

        if (i_cand > hi_bound) begin
            i_clamped = sample_t'(hi_bound);
        end else if (i_cand < lo_bound) begin
            i_clamped = sample_t'(lo_bound);
        end else begin
            i_clamped = i_cand;
        end

        out_sum = p_term + i_clamped + d_term;
        if (out_sum > LIM_MAX) begin
            out_next = LIM_MAX;
        end else if (out_sum < LIM_MIN) begin
            out_next = LIM_MIN;
        end else begin
            out_next = sample_t'(out_sum);
        end
    end

    always_ff @(posedge i_clock or negedge i_reset) begin
        if (!i_reset) begin
            integ <= '0;
            prev_error <= '0;
            prev_deriv <= '0;
            o_out <= '0;
            o_out_valid <= 1'b0;
        end else begin
            o_out_valid <= i_iterate;
            if (i_iterate) begin
                integ <= i_clamped;
                prev_error <= error;
                prev_deriv <= d_term;
                o_out <= out_next;
            end
        end
    end

    a_out_in_limits: assert property (
        @(posedge i_clock) disable iff (!i_reset)
        (o_out <= LIM_MAX) && (o_out >= LIM_MIN)
    );

endmodule

/* rtl/pid_ctrl_top.sv */
`timescale 1ns/1ps

module pid_ctrl_top import pid_pkg::*; (
    input  logic    i_clock,
    input  logic    i_reset,
    input  logic    i_write_enable,
    input  addr_t   i_reg_addr,
    input  sample_t i_reg_data,
    input  sample_t i_target,
    input  sample_t i_measurement,
    input  logic    i_enable,
    output sample_t o_out,
    output logic    o_out_valid
);

    period_t period;
    logic period_load;
    logic iterate;

    pid_coef_if u_coef ();

    pid_coef_regs u_regs (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_write_enable (i_write_enable),
        .i_reg_addr     (i_reg_addr),
        .i_reg_data     (i_reg_data),
        .coef           (u_coef.regs),
        .o_period       (period),
        .o_period_load  (period_load)
    );

    pid_iter_timer u_timer (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_enable      (i_enable),
        .i_period      (period),
        .i_period_load (period_load),
        .o_iterate     (iterate)
    );

    pid_core u_core (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_iterate     (iterate),
        .i_target      (i_target),
        .i_measurement (i_measurement),
        .coef          (u_coef.core),
        .o_out         (o_out),
        .o_out_valid   (o_out_valid)
    );

endmodule

/* rtl/pid_iter_timer.sv */
`timescale 1ns/1ps

module pid_iter_timer import pid_pkg::*; (
    input  logic    i_clock,
    input  logic    i_reset,
    input  logic    i_enable,
    input  period_t i_period,
    input  logic    i_period_load,
    output logic    o_iterate
);

    timer_state_t state;
    period_t count;
    logic can_run;

    assign can_run = i_enable && (i_period != '0);

    always_ff @(posedge i_clock or negedge i_reset) begin
        if (!i_reset) begin
            state <= TIMER_IDLE;
            count <= '0;
            o_iterate <= 1'b0;
        end else begin
            o_iterate <= 1'b0;
            case (state)
                TIMER_IDLE: begin
                    if (can_run) begin
                        state <= TIMER_RUN;
                        count <= i_period - 1'b1; // first pulse lands one period after entry.
                    end
                end
                TIMER_RUN: begin
                    if (!can_run) begin
                        state <= TIMER_IDLE;
                    end else if (i_period_load) begin
                        count <= i_period - 1'b1;
                    end else if (count == '0) begin
                        o_iterate <= 1'b1;
                        count <= i_period - 1'b1;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: begin
                    state <= TIMER_IDLE;
                end
            endcase
        end
    end

    // the core holds only one iteration, so pulses must be separated.
    a_iterate_single: assert property (
        @(posedge i_clock) disable iff (!i_reset)
        o_iterate |=> !o_iterate
    );

endmodule

/* rtl/pid_pkg.sv */
package pid_pkg;

    localparam int D_WIDTH = 18;
    localparam int Q_BITS = 15; // fraction bits of every gain.
    localparam int PERIOD_WIDTH = 16;

    typedef logic signed [D_WIDTH-1:0] sample_t;
    typedef logic signed [D_WIDTH-1:0] coef_t;
    typedef logic signed [2*D_WIDTH-1:0] product_t;
    typedef logic [2:0] addr_t;
    typedef logic [PERIOD_WIDTH-1:0] period_t;

    // output saturation, which also bounds the integrator headroom.
    localparam sample_t LIM_MAX = sample_t'(4096);
    localparam sample_t LIM_MIN = sample_t'(-4096);

    localparam addr_t ADDR_KP = 3'd0;
    localparam addr_t ADDR_KI = 3'd1;
    localparam addr_t ADDR_KD1 = 3'd2;
    localparam addr_t ADDR_KD2 = 3'd3;
    localparam addr_t ADDR_PERIOD = 3'd4;

    // shortest loop period that still leaves a gap between iterate pulses.
    localparam period_t PERIOD_MIN = period_t'(2);

    typedef enum logic {
        TIMER_IDLE,
        TIMER_RUN
    } timer_state_t;

endpackage

/* sources.f */
+incdir+verif
rtl/pid_pkg.sv
rtl/pid_coef_if.sv
rtl/pid_coef_regs.sv
rtl/pid_iter_timer.sv
rtl/pid_core.sv
rtl/pid_ctrl_top.sv
verif/tb_pid_ctrl.sv

/* verif/tb_pid_model.svh */
`ifndef TB_PID_MODEL_SVH
`define TB_PID_MODEL_SVH

// controller state as the model sees it, advanced once per o_out_valid.
longint m_integ = 0;
longint m_prev_err = 0;
longint m_prev_deriv = 0;
sample_t exp_out = '0;

function automatic longint limit_to(input longint value, input longint lo, input longint hi);
    if (value > hi) begin
        return hi;
    end
    if (value < lo) begin
        return lo;
    end
    return value;
endfunction

task automatic model_step(
    input longint tgt,
    input longint meas,
    input longint kp,
    input longint ki,
    input longint kd_1,
    input longint kd_2
);
    longint err;
    longint p_term;
    longint i_cand;
    longint d_term;
    longint hi_bound;
    longint lo_bound;
    longint integ;
    err = tgt - meas;
    p_term = (err * kp) >>> Q_BITS;
    i_cand = m_integ + ((ki * (err + m_prev_err)) >>> Q_BITS); // trapezoidal step.
    d_term = ((kd_1 * (err - m_prev_err)) >>> Q_BITS) + ((kd_2 * m_prev_deriv) >>> Q_BITS);
    // the integrator only gets the headroom left by the proportional term.
    hi_bound = (longint'(LIM_MAX) - p_term > 0) ? longint'(LIM_MAX) - p_term : 0;
    lo_bound = (longint'(LIM_MIN) - p_term < 0) ? longint'(LIM_MIN) - p_term : 0;
    integ = limit_to(i_cand, lo_bound, hi_bound);
    exp_out = sample_t'(limit_to(p_term + integ + d_term, LIM_MIN, LIM_MAX));
    m_integ = integ;
    m_prev_err = err;
    m_prev_deriv = d_term;
endtask

`endif

/* verif/tb_pid_ctrl.sv */
`timescale 1ns/1ps

module tb_pid_ctrl import pid_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES = 40;
    localparam int RATE_ITERS = 21; // seven pulses for each of three periods.
    localparam int RATE_MAX_PERIOD = 7;
    localparam int RUN_PERIOD = 4;
    localparam int PROP_ITERS = 12;
    localparam int INTEG_ITERS = 24; // per sign of the error.
    localparam int DERIV_ITERS = 14;
    localparam int SAT_ITERS = 8; // for each of the three phases.
    localparam int MARGIN_CYCLES = 200;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CYCLES + RATE_ITERS * RATE_MAX_PERIOD
        + (PROP_ITERS + 2 * INTEG_ITERS + DERIV_ITERS + 3 * SAT_ITERS) * RUN_PERIOD
        + MARGIN_CYCLES;

    logic clock;
    logic reset;
    logic write_enable;
    addr_t reg_addr;
    sample_t reg_data;
    sample_t target;
    sample_t measurement;
    logic enable;
    sample_t out_value;
    logic out_valid;

    // shadow of the gain registers, and everything the core saw at the last rising edge.
    coef_t m_kp;
    coef_t m_ki;
    coef_t m_kd_1;
    coef_t m_kd_2;
    sample_t cap_target;
    sample_t cap_meas;
    coef_t cap_kp;
    coef_t cap_ki;
    coef_t cap_kd_1;
    coef_t cap_kd_2;

    int cycle = 0;
    int last_valid = 0;
    logic have_last = 1'b0;
    logic rate_check;
    int exp_period;
    logic quiet;
    int error_count = 0;
    int max_hits = 0;
    int min_hits = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    `include "tb_pid_model.svh"

    pid_ctrl_top i_dut (
        .i_clock        (clock),
        .i_reset        (reset),
        .i_write_enable (write_enable),
        .i_reg_addr     (reg_addr),
        .i_reg_data     (reg_data),
        .i_target       (target),
        .i_measurement  (measurement),
        .i_enable       (enable),
        .o_out          (out_value),
        .o_out_valid    (out_valid)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before all tests completed, o_out_valid stopped arriving");
        $display("Simulation finished: FAIL");
        $finish;
    end

    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            m_kp <= '0;
            m_ki <= '0;
            m_kd_1 <= '0;
            m_kd_2 <= '0;
        end else if (write_enable) begin
            case (reg_addr)
                ADDR_KP: m_kp <= reg_data;
                ADDR_KI: m_ki <= reg_data;
                ADDR_KD1: m_kd_1 <= reg_data;
                ADDR_KD2: m_kd_2 <= reg_data;
                default: begin
                end
            endcase
        end
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
        cap_target <= target;
        cap_meas <= measurement;
        cap_kp <= m_kp;
        cap_ki <= m_ki;
        cap_kd_1 <= m_kd_1;
        cap_kd_2 <= m_kd_2;
        if (!rate_check) begin
            have_last <= 1'b0;
        end else if (out_valid) begin
            have_last <= 1'b1;
        end
        if (out_valid) begin
            last_valid <= cycle;
            if (out_value == LIM_MAX) max_hits <= max_hits + 1;
            if (out_value == LIM_MIN) min_hits <= min_hits + 1;
        end
    end

    // the value checked at the end of the valid cycle comes from the edge that raised it.
    always @(negedge clock) begin
        if (reset && out_valid) begin
            model_step(cap_target, cap_meas, cap_kp, cap_ki, cap_kd_1, cap_kd_2);
        end
    end

    a_idle_quiet: assert property (@(posedge clock) disable iff (!reset)
        quiet |-> (out_value == '0 && !out_valid))
    else begin
        error_count = error_count + 1;
        $display("Error: o_out = 0x%h, o_out_valid = 0x%h while idle, expected 0x0",
            $sampled(out_value), $sampled(out_valid));
    end

    a_loop_rate: assert property (@(posedge clock) disable iff (!reset)
        (rate_check && have_last && out_valid) |-> (cycle - last_valid == exp_period))
    else begin
        error_count = error_count + 1;
        $display("Error: o_out_valid spacing = 0x%h, expected 0x%h",
            $sampled(cycle - last_valid), $sampled(exp_period));
    end

    a_out_match: assert property (@(posedge clock) disable iff (!reset)
        out_valid |-> (out_value == exp_out))
    else begin
        error_count = error_count + 1;
        $display("Error: o_out = 0x%h, expected 0x%h", $sampled(out_value), $sampled(exp_out));
    end

    function automatic int random_in(input int lo, input int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    // returns at the falling edge inside the valid cycle.
    task automatic wait_valid();
        do @(negedge clock); while (out_valid !== 1'b1);
    endtask

    task automatic write_reg(input addr_t addr, input int value);
        @(negedge clock);
        write_enable = 1'b1;
        reg_addr = addr;
        reg_data = sample_t'(value);
        @(negedge clock);
        write_enable = 1'b0;
    endtask

    task automatic check_rate(input int written, input int spacing);
        rate_check = 1'b0;
        exp_period = spacing;
        write_reg(ADDR_PERIOD, written);
        wait_valid(); // the first pulses may still come from the old count.
        wait_valid();
        rate_check = 1'b1;
        repeat (5) wait_valid();
        rate_check = 1'b0;
    endtask

    task automatic finish_test(input int number, input string name, input int start_errors);
        if (error_count == start_errors) begin
            tests_passed++;
            $display("test %0d (%s): passed", number, name);
        end else begin
            tests_failed++;
            $display("test %0d (%s): failed with %0d errors", number, name,
                error_count - start_errors);
        end
    endtask

    initial begin
        int start;
        int hits;
        void'($urandom(36));
        reset = 1'b0;
        write_enable = 1'b0;
        reg_addr = '0;
        reg_data = '0;
        target = '0;
        measurement = '0;
        enable = 1'b0;
        quiet = 1'b1;
        rate_check = 1'b0;
        exp_period = 0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;

        start = error_count;
        repeat (IDLE_CYCLES / 2) @(negedge clock);
        enable = 1'b1; // period is still zero, so the timer stays idle.
        repeat (IDLE_CYCLES / 2) @(negedge clock);
        quiet = 1'b0;
        finish_test(1, "reset and idle", start);

        start = error_count;
        check_rate(5, 5);
        check_rate(1, PERIOD_MIN);
        check_rate(RATE_MAX_PERIOD, RATE_MAX_PERIOD);
        finish_test(2, "loop rate", start);

        start = error_count;
        write_reg(ADDR_PERIOD, RUN_PERIOD);
        write_reg(ADDR_KI, 0);
        write_reg(ADDR_KD1, 0);
        write_reg(ADDR_KD2, 0);
        write_reg(ADDR_KP, random_in(4096, 16384));
        for (int i = 0; i < PROP_ITERS; i++) begin
            wait_valid();
            target = sample_t'(random_in(-8192, 8191));
            measurement = sample_t'(random_in(-8192, 8191));
        end
        finish_test(3, "proportional only", start);

        start = error_count;
        target = sample_t'(2000);
        measurement = '0;
        write_reg(ADDR_KP, 8192);
        write_reg(ADDR_KI, 3000);
        hits = max_hits;
        repeat (INTEG_ITERS) wait_valid();
        assert (max_hits > hits) else begin
            error_count = error_count + 1;
            $display("integrator never reached the anti-windup bound");
        end
        target = sample_t'(-2000);
        repeat (INTEG_ITERS) wait_valid();
        finish_test(4, "integral with anti-windup", start);

        start = error_count;
        target = '0;
        measurement = '0;
        write_reg(ADDR_KP, 0);
        write_reg(ADDR_KI, 0);
        write_reg(ADDR_KD1, 16384);
        write_reg(ADDR_KD2, 16384);
        repeat (4) wait_valid();
        measurement = sample_t'(-3000); // the derivative of this step halves on each iteration.
        repeat (DERIV_ITERS - 4) wait_valid();
        finish_test(5, "filtered derivative", start);

        start = error_count;
        write_reg(ADDR_KD1, 0);
        write_reg(ADDR_KD2, 0);
        write_reg(ADDR_KP, 100000);
        target = sample_t'(8000);
        measurement = '0;
        hits = max_hits;
        repeat (SAT_ITERS) wait_valid();
        assert (max_hits > hits) else begin
            error_count = error_count + 1;
            $display("o_out never reached the upper limit");
        end
        target = sample_t'(-8000);
        hits = min_hits;
        repeat (SAT_ITERS) wait_valid();
        assert (min_hits > hits) else begin
            error_count = error_count + 1;
            $display("o_out never reached the lower limit");
        end
        target = sample_t'(2000);
        write_reg(ADDR_KP, 4096);
        repeat (SAT_ITERS) wait_valid();
        finish_test(6, "saturation and live gain change", start);

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
